// File: sim.f
design/axis_constant_pkg.sv
design/axil_register_cu.sv
design/axis_constant.sv
design/axis_constant_top.sv
sim/tb_axis_constant.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into a log and judge the result from that log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_axis_constant \
    -f sim.f -o tb_axis_constant
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_axis_constant > "$log" 2>&1
status=$?
cat "$log"

if grep -q "FAIL: see errors above" "$log"; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi
if ! grep -q "PASS: all tests" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
exit 0

// File: sim/tb_axis_constant.sv
// Self-checking testbench for the constant injector, compiled as the simulation top from sim.f
module tb_axis_constant;

    logic clock;
    logic reset;
    logic sync;
    logic [axis_constant_pkg::axil_addr_width-1:0]   axil_awaddr;
    logic                                            axil_awvalid;
    logic                                            axil_awready;
    logic [axis_constant_pkg::axil_data_width-1:0]   axil_wdata;
    logic                                            axil_wvalid;
    logic                                            axil_wready;
    axis_constant_pkg::axil_resp_t                   axil_bresp;
    logic                                            axil_bvalid;
    logic                                            axil_bready;
    logic [axis_constant_pkg::axil_addr_width-1:0]   axil_araddr;
    logic                                            axil_arvalid;
    logic                                            axil_arready;
    logic [axis_constant_pkg::axil_data_width-1:0]   axil_rdata;
    axis_constant_pkg::axil_resp_t                   axil_rresp;
    logic                                            axil_rvalid;
    logic                                            axil_rready;
    logic [axis_constant_pkg::stream_data_width-1:0] stream_data;
    logic [axis_constant_pkg::stream_dest_width-1:0] stream_dest;
    logic                                            stream_valid;
    logic                                            stream_ready;

    // Mirror of the three registers held by the reference model
    logic [axis_constant_pkg::axil_data_width-1:0] mirror [axis_constant_pkg::n_registers];

    // Expected beats in order, each with the cycle on which it has to appear
    logic [axis_constant_pkg::stream_data_width-1:0] exp_data [$];
    logic [axis_constant_pkg::stream_dest_width-1:0] exp_dest [$];
    int exp_due [$];

    int cycle = 0;
    int ops_issued = 0;

    axis_constant_top u_axis_constant_top (
        .clock(clock), .reset(reset), .sync(sync),
        .axil_awaddr(axil_awaddr), .axil_awvalid(axil_awvalid), .axil_awready(axil_awready),
        .axil_wdata(axil_wdata), .axil_wvalid(axil_wvalid), .axil_wready(axil_wready),
        .axil_bresp(axil_bresp), .axil_bvalid(axil_bvalid), .axil_bready(axil_bready),
        .axil_araddr(axil_araddr), .axil_arvalid(axil_arvalid), .axil_arready(axil_arready),
        .axil_rdata(axil_rdata), .axil_rresp(axil_rresp), .axil_rvalid(axil_rvalid),
        .axil_rready(axil_rready), .stream_data(stream_data), .stream_dest(stream_dest),
        .stream_valid(stream_valid), .stream_ready(stream_ready)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Edge counter, read right after an edge it still shows the count before that edge
    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input axis_constant_pkg::axil_resp_t got,
                              input axis_constant_pkg::axil_resp_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 'h%0h expected 'h%0h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name,
                              input logic [axis_constant_pkg::axil_data_width-1:0] got,
                              input logic [axis_constant_pkg::axil_data_width-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 'h%0h expected 'h%0h", name, got, exp));
        end
    endtask

    task automatic check_beat(input logic [axis_constant_pkg::stream_data_width-1:0] got_data,
                              input logic [axis_constant_pkg::stream_data_width-1:0] exp_d,
                              input logic [axis_constant_pkg::stream_dest_width-1:0] got_dest,
                              input logic [axis_constant_pkg::stream_dest_width-1:0] exp_t);
        if (got_data !== exp_d) begin
            fail_run($sformatf("mismatch stream_data: got 'h%0h expected 'h%0h", got_data, exp_d));
        end
        if (got_dest !== exp_t) begin
            fail_run($sformatf("mismatch stream_dest: got 'h%0h expected 'h%0h", got_dest, exp_t));
        end
    endtask

    // Byte address of register i inside the window
    function automatic logic [31:0] reg_address(input int i);
        return axis_constant_pkg::base_address + 32'(4 * i);
    endfunction

    // Word index hit by an address, or -1 for anything outside the three registers
    function automatic int decode(input logic [31:0] address);
        logic [31:0] limit;
        limit = reg_address(axis_constant_pkg::n_registers);
        if (address < axis_constant_pkg::base_address || address >= limit || address[1:0] != 0) begin
            return -1;
        end
        return int'((address - axis_constant_pkg::base_address) >> 2);
    endfunction

    // Expected write response, a decoded write also lands in the mirror
    function automatic axis_constant_pkg::axil_resp_t ref_write(input logic [31:0] address,
                                                                input logic [31:0] data);
        int index;
        index = decode(address);
        if (index < 0) begin
            return axis_constant_pkg::resp_slverr;
        end
        mirror[index] = data;
        return axis_constant_pkg::resp_okay;
    endfunction

    function automatic axis_constant_pkg::axil_resp_t ref_read(input logic [31:0] address,
                                                               output logic [31:0] data);
        int index;
        index = decode(address);
        data = (index < 0) ? 32'h0 : mirror[index];
        return (index < 0) ? axis_constant_pkg::resp_slverr : axis_constant_pkg::resp_okay;
    endfunction

    // Beat built from the mirror: high word on top, low byte of the destination register
    function automatic void ref_beat(output logic [63:0] data, output logic [7:0] dest);
        data = {mirror[axis_constant_pkg::reg_const_high], mirror[axis_constant_pkg::reg_const_low]};
        dest = mirror[axis_constant_pkg::reg_const_dest][7:0];
    endfunction

    task automatic axil_write(input logic [31:0] address, input logic [31:0] data);
        axis_constant_pkg::axil_resp_t exp_resp;
        logic [63:0] beat_data;
        logic [7:0] beat_dest;
        ops_issued++;
        @(posedge clock);
        axil_awaddr <= address;
        axil_wdata <= data;
        axil_awvalid <= 1'b1;
        axil_wvalid <= 1'b1;
        axil_bready <= 1'b1;
        do begin
            @(posedge clock);
        end while (!(axil_awready && axil_wready));
        // The DUT accepts on this edge, so the mirror moves here too
        axil_awvalid <= 1'b0;
        axil_wvalid <= 1'b0;
        exp_resp = ref_write(address, data);
        if (decode(address) == 0 && stream_ready && sync) begin
            ref_beat(beat_data, beat_dest);
            exp_data.push_back(beat_data);
            exp_dest.push_back(beat_dest);
            exp_due.push_back(cycle + 2);
        end
        do begin
            @(posedge clock);
        end while (!axil_bvalid);
        axil_bready <= 1'b0;
        check_resp("axil_bresp", axil_bresp, exp_resp);
    endtask

    task automatic axil_read(input logic [31:0] address);
        axis_constant_pkg::axil_resp_t exp_resp;
        logic [31:0] exp_word;
        ops_issued++;
        @(posedge clock);
        axil_araddr <= address;
        axil_arvalid <= 1'b1;
        axil_rready <= 1'b1;
        do begin
            @(posedge clock);
        end while (!axil_arready);
        axil_arvalid <= 1'b0;
        exp_resp = ref_read(address, exp_word);
        do begin
            @(posedge clock);
        end while (!axil_rvalid);
        axil_rready <= 1'b0;
        check_resp("axil_rresp", axil_rresp, exp_resp);
        check_word("axil_rdata", axil_rdata, exp_word);
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(3, 0)) @(posedge clock);
    endtask

    // Wait out pending beats, then a few quiet cycles in which no stray beat may appear
    task automatic drain();
        while (exp_due.size() != 0) @(posedge clock);
        repeat (4) @(posedge clock);
    endtask

    task automatic set_stream_inputs(input logic ready, input logic strobe);
        drain();
        @(posedge clock);
        stream_ready <= ready;
        sync <= strobe;
    endtask

    // Stream monitor, each valid cycle is matched against the oldest expected beat
    initial begin
        forever begin
            @(posedge clock);
            if (stream_valid === 1'b1) begin
                if (exp_due.size() == 0) begin
                    fail_run("a stream beat arrived when none was expected");
                end else if (exp_due[0] != cycle) begin
                    fail_run($sformatf("stream beat at cycle %0d, due at %0d", cycle, exp_due[0]));
                end else begin
                    check_beat(stream_data, exp_data.pop_front(), stream_dest, exp_dest.pop_front());
                    void'(exp_due.pop_front());
                end
            end else if (exp_due.size() != 0 && exp_due[0] < cycle) begin
                fail_run("an expected stream beat never arrived");
            end
        end
    end

    // The budget grows with every bus operation that gets started
    initial begin
        forever begin
            @(posedge clock);
            if (cycle > 200 * (ops_issued + 1)) begin
                fail_run("timeout: the DUT stopped completing bus operations");
            end
        end
    end

    initial begin
        void'($urandom(28926));
        reset = 1'b0;
        sync = 1'b0;
        stream_ready = 1'b0;
        axil_awaddr = '0;
        axil_awvalid = 1'b0;
        axil_wdata = '0;
        axil_wvalid = 1'b0;
        axil_bready = 1'b0;
        axil_araddr = '0;
        axil_arvalid = 1'b0;
        axil_rready = 1'b0;
        for (int i = 0; i < axis_constant_pkg::n_registers; i++) mirror[i] = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b1;

        // Registers come out of reset as zero and the stream stays quiet
        for (int i = 0; i < axis_constant_pkg::n_registers; i++) axil_read(reg_address(i));
        repeat (20) @(posedge clock);

        // Read-back with the sink stalled so no beat can leave
        repeat (4) begin
            for (int i = 0; i < axis_constant_pkg::n_registers; i++) begin
                axil_write(reg_address(i), $urandom());
                idle_gap();
            end
            for (int i = 0; i < axis_constant_pkg::n_registers; i++) axil_read(reg_address(i));
        end

        // Only the low word write fires a beat
        set_stream_inputs(1'b1, 1'b1);
        repeat (4) begin
            axil_write(reg_address(axis_constant_pkg::reg_const_high), $urandom());
            idle_gap();
            axil_write(reg_address(axis_constant_pkg::reg_const_dest), $urandom());
            idle_gap();
            axil_write(reg_address(axis_constant_pkg::reg_const_low), $urandom());
            drain();
        end

        // A trigger with sync low or the sink stalled is lost but the register still updates
        set_stream_inputs(1'b1, 1'b0);
        axil_write(reg_address(axis_constant_pkg::reg_const_low), $urandom());
        axil_read(reg_address(axis_constant_pkg::reg_const_low));
        set_stream_inputs(1'b0, 1'b1);
        axil_write(reg_address(axis_constant_pkg::reg_const_low), $urandom());
        axil_read(reg_address(axis_constant_pkg::reg_const_low));

        // Past the last register and far outside the window
        set_stream_inputs(1'b1, 1'b1);
        axil_write(reg_address(3), $urandom());
        axil_write(32'h0000_1000, $urandom());
        axil_read(reg_address(3));
        axil_read(32'h0000_1000);
        for (int i = 0; i < axis_constant_pkg::n_registers; i++) axil_read(reg_address(i));
        drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: design/axis_constant_top.sv
// Top level of the constant injector, joining the AXI-lite register block to the stream source
module axis_constant_top (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            sync,
    input  logic [axis_constant_pkg::axil_addr_width-1:0]   axil_awaddr,
    input  logic                                            axil_awvalid,
    output logic                                            axil_awready,
    input  logic [axis_constant_pkg::axil_data_width-1:0]   axil_wdata,
    input  logic                                            axil_wvalid,
    output logic                                            axil_wready,
    output axis_constant_pkg::axil_resp_t                   axil_bresp,
    output logic                                            axil_bvalid,
    input  logic                                            axil_bready,
    input  logic [axis_constant_pkg::axil_addr_width-1:0]   axil_araddr,
    input  logic                                            axil_arvalid,
    output logic                                            axil_arready,
    output logic [axis_constant_pkg::axil_data_width-1:0]   axil_rdata,
    output axis_constant_pkg::axil_resp_t                   axil_rresp,
    output logic                                            axil_rvalid,
    input  logic                                            axil_rready,
    output logic [axis_constant_pkg::stream_data_width-1:0] stream_data,
    output logic [axis_constant_pkg::stream_dest_width-1:0] stream_dest,
    output logic                                            stream_valid,
    input  logic                                            stream_ready
);

    // Register values and the write trigger flowing from the control unit to the source
    logic [axis_constant_pkg::axil_data_width-1:0] const_low;
    logic [axis_constant_pkg::axil_data_width-1:0] const_high;
    logic [axis_constant_pkg::axil_data_width-1:0] const_dest;
    logic                                          trigger;

    axil_register_cu u_register_cu (
        .clock        (clock),
        .reset        (reset),
        .axil_awaddr  (axil_awaddr),
        .axil_awvalid (axil_awvalid),
        .axil_awready (axil_awready),
        .axil_wdata   (axil_wdata),
        .axil_wvalid  (axil_wvalid),
        .axil_wready  (axil_wready),
        .axil_bresp   (axil_bresp),
        .axil_bvalid  (axil_bvalid),
        .axil_bready  (axil_bready),
        .axil_araddr  (axil_araddr),
        .axil_arvalid (axil_arvalid),
        .axil_arready (axil_arready),
        .axil_rdata   (axil_rdata),
        .axil_rresp   (axil_rresp),
        .axil_rvalid  (axil_rvalid),
        .axil_rready  (axil_rready),
        .const_low    (const_low),
        .const_high   (const_high),
        .const_dest   (const_dest),
        .trigger      (trigger)
    );

    axis_constant u_constant (
        .clock        (clock),
        .reset        (reset),
        .sync         (sync),
        .trigger      (trigger),
        .const_low    (const_low),
        .const_high   (const_high),
        .const_dest   (const_dest),
        .stream_data  (stream_data),
        .stream_dest  (stream_dest),
        .stream_valid (stream_valid),
        .stream_ready (stream_ready)
    );

endmodule

// File: design/axis_constant.sv
// Constant source that emits one stream beat per trigger when the sink is ready and sync is high
module axis_constant (
    input  logic                                            clock,
    input  logic                                            reset,
    input  logic                                            sync,
    input  logic                                            trigger,
    input  logic [axis_constant_pkg::axil_data_width-1:0]   const_low,
    input  logic [axis_constant_pkg::axil_data_width-1:0]   const_high,
    input  logic [axis_constant_pkg::axil_data_width-1:0]   const_dest,
    output logic [axis_constant_pkg::stream_data_width-1:0] stream_data,
    output logic [axis_constant_pkg::stream_dest_width-1:0] stream_dest,
    output logic                                            stream_valid,
    input  logic                                            stream_ready
);

    logic fire;

    // A trigger is only honoured when the sink and the external sync agree in the same cycle
    assign fire = trigger && stream_ready && sync;

    // Valid is a single-cycle pulse and never waits for the sink
    always_ff @(posedge clock) begin
        if (!reset) begin
            stream_valid <= 1'b0;
        end else begin
            stream_valid <= fire;
        end
    end

    // Data and dest keep the last beat's values between triggers
    always_ff @(posedge clock) begin
        if (!reset) begin
            stream_data <= '0;
            stream_dest <= '0;
        end else if (fire) begin
            // High word sits in the upper half of the beat
            stream_data <= {const_high, const_low};
            // Only the low byte of the destination register reaches the stream
            stream_dest <= const_dest[axis_constant_pkg::stream_dest_width-1:0];
        end
    end

endmodule

// File: design/axil_register_cu.sv
// AXI-lite slave holding the three constant registers and raising a trigger on low-word writes
module axil_register_cu (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic [axis_constant_pkg::axil_addr_width-1:0] axil_awaddr,
    input  logic                                          axil_awvalid,
    output logic                                          axil_awready,
    input  logic [axis_constant_pkg::axil_data_width-1:0] axil_wdata,
    input  logic                                          axil_wvalid,
    output logic                                          axil_wready,
    output axis_constant_pkg::axil_resp_t                 axil_bresp,
    output logic                                          axil_bvalid,
    input  logic                                          axil_bready,
    input  logic [axis_constant_pkg::axil_addr_width-1:0] axil_araddr,
    input  logic                                          axil_arvalid,
    output logic                                          axil_arready,
    output logic [axis_constant_pkg::axil_data_width-1:0] axil_rdata,
    output axis_constant_pkg::axil_resp_t                 axil_rresp,
    output logic                                          axil_rvalid,
    input  logic                                          axil_rready,
    output logic [axis_constant_pkg::axil_data_width-1:0] const_low,
    output logic [axis_constant_pkg::axil_data_width-1:0] const_high,
    output logic [axis_constant_pkg::axil_data_width-1:0] const_dest,
    output logic                                          trigger
);

    logic [axis_constant_pkg::axil_data_width-1:0] registers [axis_constant_pkg::n_registers];

    axis_constant_pkg::wr_state_t wr_state;
    axis_constant_pkg::rd_state_t rd_state;

    logic wr_accept;
    logic wr_hit;
    axis_constant_pkg::reg_index_t wr_index;
    logic rd_accept;
    logic rd_hit;
    axis_constant_pkg::reg_index_t rd_index;

    // True when the address lands word-aligned on one of the implemented registers
    function automatic logic address_hit(
        input logic [axis_constant_pkg::axil_addr_width-1:0] address
    );
        logic [axis_constant_pkg::axil_addr_width-1:0] offset;
        offset = address - axis_constant_pkg::base_address;
        return (offset[1:0] == 2'b00) &&
               (offset[axis_constant_pkg::axil_addr_width-1:2] < axis_constant_pkg::n_registers);
    endfunction

    // Word index of the address inside the register window
    function automatic axis_constant_pkg::reg_index_t address_index(
        input logic [axis_constant_pkg::axil_addr_width-1:0] address
    );
        logic [axis_constant_pkg::axil_addr_width-1:0] offset;
        offset = address - axis_constant_pkg::base_address;
        return axis_constant_pkg::reg_index_t'(offset[3:2]);
    endfunction

    // Readies were raised on the previous edge, so this edge completes the handshake
    assign wr_accept = (wr_state == axis_constant_pkg::wr_idle) && axil_awready &&
                       axil_awvalid && axil_wvalid;
    assign rd_accept = (rd_state == axis_constant_pkg::rd_idle) && axil_arready && axil_arvalid;

    assign wr_hit = address_hit(axil_awaddr);
    assign wr_index = address_index(axil_awaddr);
    assign rd_hit = address_hit(axil_araddr);
    assign rd_index = address_index(axil_araddr);

    assign const_low = registers[axis_constant_pkg::reg_const_low];
    assign const_high = registers[axis_constant_pkg::reg_const_high];
    assign const_dest = registers[axis_constant_pkg::reg_const_dest];

    // Write channel FSM, register file and trigger pulse
    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_state <= axis_constant_pkg::wr_idle;
            axil_awready <= 1'b0;
            axil_wready <= 1'b0;
            axil_bvalid <= 1'b0;
            trigger <= 1'b0;
            for (int i = 0; i < axis_constant_pkg::n_registers; i++) begin
                registers[i] <= '0;
            end
        end else begin
            // The trigger only ever lasts a single cycle
            trigger <= 1'b0;
            case (wr_state)
                axis_constant_pkg::wr_idle: begin
                    if (wr_accept) begin
                        axil_awready <= 1'b0;
                        axil_wready <= 1'b0;
                        axil_bvalid <= 1'b1;
                        wr_state <= axis_constant_pkg::wr_resp;
                        // Undecoded addresses leave every register untouched
                        if (wr_hit) begin
                            registers[wr_index] <= axil_wdata;
                            trigger <= (wr_index == axis_constant_pkg::trigger_register);
                        end
                    end else begin
                        // Offer both readies together for one cycle once address and data wait
                        axil_awready <= axil_awvalid && axil_wvalid && !axil_awready;
                        axil_wready <= axil_awvalid && axil_wvalid && !axil_awready;
                    end
                end
                axis_constant_pkg::wr_resp: begin
                    if (axil_bready) begin
                        axil_bvalid <= 1'b0;
                        wr_state <= axis_constant_pkg::wr_idle;
                    end
                end
                default: wr_state <= axis_constant_pkg::wr_idle;
            endcase
        end
    end

    // Write response code is captured with the accepted transaction
    always_ff @(posedge clock) begin
        if (wr_accept) begin
            axil_bresp <= wr_hit ? axis_constant_pkg::resp_okay : axis_constant_pkg::resp_slverr;
        end
    end

    // Read channel FSM, it runs independently of the write side
    always_ff @(posedge clock) begin
        if (!reset) begin
            rd_state <= axis_constant_pkg::rd_idle;
            axil_arready <= 1'b0;
            axil_rvalid <= 1'b0;
        end else begin
            case (rd_state)
                axis_constant_pkg::rd_idle: begin
                    if (rd_accept) begin
                        axil_arready <= 1'b0;
                        axil_rvalid <= 1'b1;
                        rd_state <= axis_constant_pkg::rd_data;
                    end else begin
                        axil_arready <= axil_arvalid && !axil_arready;
                    end
                end
                axis_constant_pkg::rd_data: begin
                    if (axil_rready) begin
                        axil_rvalid <= 1'b0;
                        rd_state <= axis_constant_pkg::rd_idle;
                    end
                end
                default: rd_state <= axis_constant_pkg::rd_idle;
            endcase
        end
    end

    // Read data and response, an undecoded read returns zero
    always_ff @(posedge clock) begin
        if (rd_accept) begin
            if (rd_hit) begin
                axil_rdata <= registers[rd_index];
                axil_rresp <= axis_constant_pkg::resp_okay;
            end else begin
                axil_rdata <= '0;
                axil_rresp <= axis_constant_pkg::resp_slverr;
            end
        end
    end

endmodule

// File: design/axis_constant_pkg.sv
// Shared widths, register map, response codes and FSM states for the AXI-lite constant injector
package axis_constant_pkg;

    // AXI-lite bus geometry, the registers are as wide as the data bus
    localparam int axil_addr_width = 32;
    localparam int axil_data_width = 32;
    localparam int n_registers = 3;

    // The stream beat carries the high word followed by the low word
    localparam int stream_data_width = 64;
    localparam int stream_dest_width = 8;

    // Byte address of register 0, each further register is one word up
    localparam logic [axil_addr_width-1:0] base_address = 32'h43c00000;

    typedef enum logic [1:0] {
        reg_const_low = 2'd0,
        reg_const_high = 2'd1,
        reg_const_dest = 2'd2
    } reg_index_t;

    // A write landing on this register fires the stream beat
    localparam reg_index_t trigger_register = reg_const_low;

    typedef enum logic [1:0] {
        resp_okay = 2'd0,
        resp_slverr = 2'd2
    } axil_resp_t;

    typedef enum logic {
        wr_idle,
        wr_resp
    } wr_state_t;

    typedef enum logic {
        rd_idle,
        rd_data
    } rd_state_t;

endpackage
